// File: filelist.f
+incdir+common
common/mem_bus_pkg.sv
common/cache_types_pkg.sv
cache/cache_array.sv
cache/cache_ctrl.sv
cache/flush_walker.sv
cache/mem_arbiter.sv
cache/l1_cache.sv
verification/l1_cache_assert.sv
verification/l1_cache_tb.sv

// File: verification/l1_cache_tb.sv
`timescale 1ns/1ps

`include "cache_settings.svh"

module l1_cache_tb import mem_bus_pkg::*; ();

    localparam int          CLK_PERIOD  = 4;
    localparam int          N_ROWS      = 30;
    localparam int          BLOCK_BYTES = `BLOCK_WORDS * 4;
    localparam word_t       NC          = `NONCACHE_START;
    localparam logic [31:0] SEED        = 32'h4518d1b4;

    typedef enum logic [2:0] {
        OP_READ,        // read with its result compared
        OP_FETCH,       // read that must go to memory
        OP_WRITE,
        OP_FLUSH,
        OP_MEMCHK,      // compare the memory model's block
        OP_POKE         // change the memory model behind the cache
    } op_t;

    typedef struct packed {
        op_t      op;
        word_t    addr;
        word_t    data;
        byte_en_t be;
        word_t    exp;
    } row_t;

    // op, address, data, byte enable, expected word
    row_t rows [N_ROWS] = '{
        '{OP_FETCH,  32'h0000_0040, 32'h0000_0000, 4'hf, 32'h0000_0040},
        '{OP_READ,   32'h0000_0040, 32'h0000_0000, 4'hf, 32'h0000_0040},
        '{OP_WRITE,  32'h0000_0040, 32'hAABB_CCDD, 4'h1, 32'h0000_0000},
        '{OP_READ,   32'h0000_0040, 32'h0000_0000, 4'hf, 32'h0000_00DD},
        '{OP_WRITE,  32'h0000_0040, 32'h1122_3344, 4'hc, 32'h0000_0000},
        '{OP_READ,   32'h0000_0040, 32'h0000_0000, 4'hf, 32'h1122_00DD},
        '{OP_WRITE,  32'h0000_0040, 32'hCAFE_F00D, 4'hf, 32'h0000_0000},
        '{OP_READ,   32'h0000_0040, 32'h0000_0000, 4'hf, 32'hCAFE_F00D},
        '{OP_FETCH,  32'h0000_0444, 32'h0000_0000, 4'hf, 32'h0000_0444},
        '{OP_MEMCHK, 32'h0000_0040, 32'h0000_0000, 4'hf, 32'hCAFE_F00D},
        '{OP_WRITE,  32'h0000_0208, 32'h5555_AAAA, 4'hf, 32'h0000_0000},
        '{OP_READ,   32'h0000_0208, 32'h0000_0000, 4'hf, 32'h5555_AAAA},
        '{OP_FETCH,  32'h0000_0608, 32'h0000_0000, 4'hf, 32'h0000_0608},
        '{OP_MEMCHK, 32'h0000_0208, 32'h0000_0000, 4'hf, 32'h5555_AAAA},
        '{OP_READ,   NC + 32'h104,  32'h0000_0000, 4'hf, NC + 32'h104},
        '{OP_WRITE,  NC + 32'h010,  32'h1234_5678, 4'hf, 32'h0000_0000},
        '{OP_READ,   NC + 32'h010,  32'h0000_0000, 4'hf, 32'h1234_5678},
        '{OP_POKE,   NC + 32'h010,  32'h8765_4321, 4'hf, 32'h0000_0000},
        '{OP_READ,   NC + 32'h010,  32'h0000_0000, 4'hf, 32'h8765_4321},
        '{OP_WRITE,  32'h0000_0300, 32'h0101_0101, 4'hf, 32'h0000_0000},
        '{OP_WRITE,  32'h0000_0354, 32'h0202_0202, 4'hf, 32'h0000_0000},
        '{OP_WRITE,  32'h0000_0080, 32'h0303_0303, 4'hf, 32'h0000_0000},
        '{OP_FLUSH,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000},
        '{OP_MEMCHK, 32'h0000_0300, 32'h0000_0000, 4'hf, 32'h0101_0101},
        '{OP_MEMCHK, 32'h0000_0354, 32'h0000_0000, 4'hf, 32'h0202_0202},
        '{OP_MEMCHK, 32'h0000_0080, 32'h0000_0000, 4'hf, 32'h0303_0303},
        '{OP_FETCH,  32'h0000_0300, 32'h0000_0000, 4'hf, 32'h0101_0101},
        '{OP_FETCH,  32'h0000_0354, 32'h0000_0000, 4'hf, 32'h0202_0202},
        '{OP_FETCH,  32'h0000_0080, 32'h0000_0000, 4'hf, 32'h0303_0303},
        '{OP_FETCH,  32'h0000_0444, 32'h0000_0000, 4'hf, 32'h0000_0444}
    };

    logic     CLK, nRST;
    logic     ren, wen, flush;
    word_t    addr, wdata, rdata;
    byte_en_t byte_en;
    logic     busy, flush_done;
    logic     mem_ren, mem_wen, mem_busy;
    word_t    mem_addr;
    block_t   mem_wdata, mem_rdata;

    block_t   mem [word_t];     // memory model keyed by block address
    int       reads_started;    // read transfers begun by the model
    int       wait_cnt;
    word_t    req_addr;

    l1_cache UUT (
        .CLK(CLK), .nRST(nRST),
        .ren(ren), .wen(wen), .addr(addr), .wdata(wdata), .byte_en(byte_en),
        .rdata(rdata), .busy(busy), .flush(flush), .flush_done(flush_done),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                $time, what, exp, got));
        end
    endtask

    task automatic check_block(input block_t got, input block_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected block %h got %h",
                                $time, what, exp, got));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                                $time, what, exp, got));
        end
    endtask

    function automatic word_t block_base(input word_t a);
        return a & ~word_t'(BLOCK_BYTES - 1);
    endfunction

    // untouched memory holds its own address in every word
    function automatic block_t fresh_block(input word_t base);
        block_t b;
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
            b[i] = base + word_t'(4 * i);
        end
        return b;
    endfunction

    function automatic block_t model_block(input word_t a);
        if (mem.exists(block_base(a))) begin
            return mem[block_base(a)];
        end
        return fresh_block(block_base(a));
    endfunction

    function automatic block_t expected_block(input word_t a, input word_t w);
        block_t b;
        b = fresh_block(block_base(a));
        b[(a % BLOCK_BYTES) / 4] = w;   // the one word the test wrote
        return b;
    endfunction

    task automatic poke_word(input word_t a, input word_t w);
        block_t b;
        b = model_block(a);
        b[(a % BLOCK_BYTES) / 4] = w;
        mem[block_base(a)] = b;
    endtask

    // busy idles high and drops for one cycle to end a transfer
    initial begin
        void'($urandom(SEED));
        mem_busy      = 1'b1;
        mem_rdata     = '0;
        wait_cnt      = 0;
        reads_started = 0;
        forever begin
            @(posedge CLK);
            if (mem_ren && mem_wen) begin
                abort_run("memory model saw the read and write strobes high together");
            end
            if (!mem_busy) begin
                mem_busy <= 1'b1;                   // transfer ended at this edge
            end else if (wait_cnt != 0) begin
                if (mem_addr != req_addr) begin
                    abort_run("memory address changed in the middle of a transfer");
                end
                if (wait_cnt == 1) begin
                    if (mem_wen) begin
                        mem[block_base(mem_addr)] = mem_wdata;
                    end else begin
                        mem_rdata <= model_block(mem_addr);
                    end
                    mem_busy <= 1'b0;
                end
                wait_cnt <= wait_cnt - 1;
            end else if (mem_ren || mem_wen) begin
                wait_cnt <= $urandom_range(4, 1);
                req_addr <= mem_addr;
                if (mem_ren) begin
                    reads_started++;
                end
            end
        end
    end

    // starts and ends at a falling edge
    task automatic run_access(input logic is_write, input word_t a, input word_t d,
                              input byte_en_t be, output word_t got, output int fetches);
        int start;
        start = reads_started;
        @(posedge CLK);
        ren     <= !is_write;
        wen     <= is_write;
        addr    <= a;
        wdata   <= d;
        byte_en <= be;
        @(negedge CLK);
        while (busy) @(negedge CLK);
        got     = rdata;
        fetches = reads_started - start;
        @(posedge CLK);                 // access completes here
        ren <= 1'b0;
        wen <= 1'b0;
        @(negedge CLK);
    endtask

    task automatic run_flush();
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        while (!flush_done) @(negedge CLK);
    endtask

    task automatic apply_row(input int n, input row_t r);
        word_t got;
        int    fetches;
        string what;
        what = $sformatf("row %0d %s at %h", n, r.op.name(), r.addr);
        case (r.op)
            OP_READ, OP_FETCH: begin
                run_access(1'b0, r.addr, r.data, r.be, got, fetches);
                check_word(got, r.exp, what);
                if (r.op == OP_FETCH) begin
                    check_flag(fetches != 0, 1'b1, {what, " memory read"});
                end
            end
            OP_WRITE:  run_access(1'b1, r.addr, r.data, r.be, got, fetches);
            OP_FLUSH:  run_flush();
            OP_MEMCHK: check_block(model_block(r.addr), expected_block(r.addr, r.exp), what);
            OP_POKE:   poke_word(r.addr, r.data);
            default:   abort_run("unknown operation in the stimulus table");
        endcase
    endtask

    initial begin
        repeat (N_ROWS * 40) @(posedge CLK);
        abort_run($sformatf("timeout: the tests did not finish within %0d clock cycles",
                            N_ROWS * 40));
    end

    initial begin
        nRST    = 1'b0;
        ren     = 1'b0;
        wen     = 1'b0;
        flush   = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_flag(busy, 1'b1, "busy with no request after reset");
        check_flag(flush_done, 1'b0, "flush_done after reset");
        for (int i = 0; i < N_ROWS; i++) begin
            apply_row(i, rows[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verification/l1_cache_assert.sv
`timescale 1ns/1ps

module l1_cache_assert import mem_bus_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    input logic  mem_ren,
    input logic  mem_wen,
    input logic  mem_busy,
    input word_t mem_addr,
    input logic  flush_done
);

    // only one strobe on the memory bus at a time
    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen are high together");

    done_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done stayed high for more than one cycle");

    // open transfer keeps its address until memory releases it
    addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr))
        else $error("mem_addr changed while the memory was busy");

endmodule

bind l1_cache l1_cache_assert ASSERTS (
    .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_busy(mem_busy), .mem_addr(mem_addr), .flush_done(flush_done)
);

// File: cache/l1_cache.sv
`timescale 1ns/1ps

module l1_cache import mem_bus_pkg::*, cache_types_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    // processor side
    input  logic     ren,
    input  logic     wen,
    input  word_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    output word_t    rdata,
    output logic     busy,
    input  logic     flush,
    output logic     flush_done,
    // memory side
    output logic     mem_ren,
    output logic     mem_wen,
    output word_t    mem_addr,
    output block_t   mem_wdata,
    input  block_t   mem_rdata,
    input  logic     mem_busy
);

    logic         walk_active;
    logic         ctrl_idle;
    cache_frame_t rframe;

    // array ports
    set_idx_t     c_idx, w_idx;
    logic         c_wen, w_wen;
    cache_frame_t c_wval, c_mask, w_wval, w_mask;

    // arbiter requesters
    logic         c_req, c_we, c_gnt, c_busy;
    word_t        c_addr;
    block_t       c_wdata, c_rdata;
    logic         w_req, w_gnt, w_busy;
    word_t        w_addr;
    block_t       w_wdata;

    cache_array ARRAY (
        .CLK(CLK), .nRST(nRST), .walk_active(walk_active),
        .c_idx(c_idx), .c_wen(c_wen), .c_wval(c_wval), .c_mask(c_mask),
        .w_idx(w_idx), .w_wen(w_wen), .w_wval(w_wval), .w_mask(w_mask),
        .rframe(rframe)
    );

    cache_ctrl CTRL (
        .CLK(CLK), .nRST(nRST),
        .ren(ren), .wen(wen), .addr(addr), .wdata(wdata), .byte_en(byte_en),
        .rdata(rdata), .busy(busy), .walk_active(walk_active), .rframe(rframe),
        .idx(c_idx), .arr_wen(c_wen), .arr_wval(c_wval), .arr_mask(c_mask),
        .mreq(c_req), .mwe(c_we), .maddr(c_addr), .mwdata(c_wdata),
        .mgnt(c_gnt), .mbusy(c_busy), .mrdata(c_rdata), .idle(ctrl_idle)
    );

    flush_walker WALKER (
        .CLK(CLK), .nRST(nRST), .flush(flush), .ctrl_idle(ctrl_idle),
        .rframe(rframe), .walk_active(walk_active),
        .idx(w_idx), .arr_wen(w_wen), .arr_wval(w_wval), .arr_mask(w_mask),
        .mreq(w_req), .maddr(w_addr), .mwdata(w_wdata),
        .mgnt(w_gnt), .mbusy(w_busy), .flush_done(flush_done)
    );

    mem_arbiter ARB (
        .CLK(CLK), .nRST(nRST),
        .c_req(c_req), .c_we(c_we), .c_addr(c_addr), .c_wdata(c_wdata),
        .c_gnt(c_gnt), .c_busy(c_busy), .c_rdata(c_rdata),
        .w_req(w_req), .w_addr(w_addr), .w_wdata(w_wdata),
        .w_gnt(w_gnt), .w_busy(w_busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

endmodule

// File: cache/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_bus_pkg::*; (
    input  logic   CLK,
    input  logic   nRST,
    // controller requester
    input  logic   c_req,
    input  logic   c_we,
    input  word_t  c_addr,
    input  block_t c_wdata,
    output logic   c_gnt,
    output logic   c_busy,
    output block_t c_rdata,
    // walker requester that only writes
    input  logic   w_req,
    input  word_t  w_addr,
    input  block_t w_wdata,
    output logic   w_gnt,
    output logic   w_busy,
    // memory bus
    output logic   mem_ren,
    output logic   mem_wen,
    output word_t  mem_addr,
    output block_t mem_wdata,
    input  block_t mem_rdata,
    input  logic   mem_busy
);

    logic locked;       // transfer in flight
    logic owner_w;      // walker holds the lock
    logic pick_w, active;

    always_comb begin
        if (locked) begin
            pick_w = owner_w;
            active = 1'b1;
        end else begin
            pick_w = w_req;              // walker wins a tie
            active = w_req | c_req;
        end
    end

    assign w_gnt  = active & pick_w;
    assign c_gnt  = active & ~pick_w;
    assign w_busy = ~w_gnt | mem_busy;   // ungranted side just waits
    assign c_busy = ~c_gnt | mem_busy;

    assign mem_ren   = c_gnt & c_req & ~c_we;
    assign mem_wen   = (w_gnt & w_req) | (c_gnt & c_req & c_we);
    assign mem_addr  = pick_w ? w_addr : c_addr;
    assign mem_wdata = pick_w ? w_wdata : c_wdata;
    assign c_rdata   = mem_rdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            locked  <= 1'b0;
            owner_w <= 1'b0;
        end else begin
            locked <= active && mem_busy;   // released when memory finishes
            if (active) begin
                owner_w <= pick_w;
            end
        end
    end

endmodule

// File: cache/flush_walker.sv
`timescale 1ns/1ps

module flush_walker import mem_bus_pkg::*, cache_types_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         flush,
    input  logic         ctrl_idle,
    input  cache_frame_t rframe,
    output logic         walk_active,
    output set_idx_t     idx,
    output logic         arr_wen,
    output cache_frame_t arr_wval,
    output cache_frame_t arr_mask,
    output logic         mreq,
    output word_t        maddr,
    output block_t       mwdata,
    input  logic         mgnt,
    input  logic         mbusy,
    output logic         flush_done
);

    logic        pending;        // flush seen, walk not yet started
    set_idx_t    set_cnt;
    logic        needs_wb, step;
    cache_addr_t wb_addr;

    assign needs_wb = rframe.tag.valid && rframe.tag.dirty;
    assign step     = walk_active && (!needs_wb || (mgnt && !mbusy));

    always_comb begin
        wb_addr.f.tag   = rframe.tag.tag;
        wb_addr.f.idx   = set_cnt;
        wb_addr.f.blk   = '0;
        wb_addr.f.bytes = '0;
    end

    assign mreq     = walk_active && needs_wb;
    assign maddr    = wb_addr.raw;
    assign mwdata   = rframe.data;
    assign idx      = set_cnt;
    assign arr_wen  = step;      // clear once the frame is safe in memory
    assign arr_wval = '0;
    assign arr_mask = '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pending     <= 1'b0;
            walk_active <= 1'b0;
            set_cnt     <= '0;
            flush_done  <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            if (flush) begin
                pending <= 1'b1;
            end
            if (!walk_active) begin
                if (pending && ctrl_idle) begin
                    pending     <= 1'b0;
                    walk_active <= 1'b1;
                    set_cnt     <= '0;
                end
            end else if (step) begin
                set_cnt <= set_cnt + 1'b1;
                if (set_cnt == set_idx_t'(N_SETS - 1)) begin
                    walk_active <= 1'b0;
                    flush_done  <= 1'b1;   // single cycle
                end
            end
        end
    end

endmodule

// File: cache/cache_ctrl.sv
`timescale 1ns/1ps

`include "cache_settings.svh"

module cache_ctrl import mem_bus_pkg::*, cache_types_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         ren,
    input  logic         wen,
    input  word_t        addr,
    input  word_t        wdata,
    input  byte_en_t     byte_en,
    output word_t        rdata,
    output logic         busy,
    input  logic         walk_active,
    input  cache_frame_t rframe,
    output set_idx_t     idx,
    output logic         arr_wen,
    output cache_frame_t arr_wval,
    output cache_frame_t arr_mask,
    output logic         mreq,
    output logic         mwe,
    output word_t        maddr,
    output block_t       mwdata,
    input  logic         mgnt,
    input  logic         mbusy,
    input  block_t       mrdata,
    output logic         idle
);

    ctrl_state_t state, next_state;
    cache_addr_t a;             // live processor address
    cache_addr_t req_q;         // address of the access that missed
    cache_addr_t line_addr;     // block-aligned memory address
    logic        access, uncached, hit, victim_dirty, xfer_done;
    word_t       lane_mask, lane_data;

    assign a.raw        = addr;
    assign access       = (ren | wen) & ~walk_active;
    assign uncached     = addr >= `NONCACHE_START;
    assign hit          = rframe.tag.valid && (rframe.tag.tag == a.f.tag);
    assign victim_dirty = rframe.tag.valid && rframe.tag.dirty;
    assign xfer_done    = mgnt && !mbusy;
    assign idle         = (state == LOOKUP) && !(ren | wen);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_mask[8*i +: 8] = {8{byte_en[i]}};
        end
    end
    assign lane_data = wdata & lane_mask;   // disabled lanes zeroed

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= LOOKUP;
        end else begin
            state <= next_state;
        end
    end

    // holds the miss address once the FSM leaves LOOKUP
    always_ff @(posedge CLK) begin
        if (state == LOOKUP) begin
            req_q <= a;
        end
    end

    always_comb begin
        next_state = state;
        busy       = 1'b1;
        rdata      = '0;
        arr_wen    = 1'b0;
        arr_wval   = '0;
        arr_mask   = '1;
        mreq       = 1'b0;
        mwe        = 1'b0;
        maddr      = '0;
        mwdata     = '0;
        idx        = (state == LOOKUP) ? a.f.idx : req_q.f.idx;

        line_addr.f.tag   = req_q.f.tag;
        line_addr.f.idx   = req_q.f.idx;
        line_addr.f.blk   = '0;
        line_addr.f.bytes = '0;

        case (state)
            LOOKUP: begin
                if (access && uncached) begin
                    mreq              = 1'b1;
                    mwe               = wen;
                    maddr             = a.raw;
                    mwdata[a.f.blk]   = lane_data;
                    busy              = mbusy;
                    rdata             = mrdata[a.f.blk];
                end else if (access && hit) begin
                    busy  = 1'b0;
                    rdata = rframe.data[a.f.blk];
                    if (wen) begin
                        arr_wen                = 1'b1;
                        arr_wval.data[a.f.blk] = lane_data;
                        arr_mask.data[a.f.blk] = ~lane_mask;
                        arr_wval.tag.dirty     = 1'b1;
                        arr_mask.tag.dirty     = 1'b0;
                    end
                end else if (access) begin
                    next_state = victim_dirty ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                line_addr.f.tag = rframe.tag.tag;   // victim's own block
                mreq            = 1'b1;
                mwe             = 1'b1;
                maddr           = line_addr.raw;
                mwdata          = rframe.data;
                if (xfer_done) begin
                    arr_wen            = 1'b1;
                    arr_wval.tag.dirty = 1'b0;
                    arr_mask.tag.dirty = 1'b0;
                    next_state         = FETCH;
                end
            end
            FETCH: begin
                mreq  = 1'b1;
                maddr = line_addr.raw;
                if (xfer_done) begin
                    arr_wen            = 1'b1;
                    arr_mask           = '0;    // whole frame replaced
                    arr_wval.tag.valid = 1'b1;
                    arr_wval.tag.tag   = req_q.f.tag;
                    arr_wval.data      = mrdata;
                    next_state         = LOOKUP;  // completes there as a hit
                end
            end
            default: next_state = LOOKUP;
        endcase
    end

endmodule

// File: cache/cache_array.sv
`timescale 1ns/1ps

module cache_array import cache_types_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         walk_active,
    // controller port
    input  set_idx_t     c_idx,
    input  logic         c_wen,
    input  cache_frame_t c_wval,
    input  cache_frame_t c_mask,
    // walker port
    input  set_idx_t     w_idx,
    input  logic         w_wen,
    input  cache_frame_t w_wval,
    input  cache_frame_t w_mask,
    output cache_frame_t rframe
);

    cache_frame_t      frames [N_SETS];
    logic [N_SETS-1:0] valid_q;          // valid bit of every frame

    set_idx_t     sel;
    logic         wr;
    cache_frame_t wval, mask, stored;

    assign sel  = walk_active ? w_idx  : c_idx;
    assign wr   = walk_active ? w_wen  : c_wen;
    assign wval = walk_active ? w_wval : c_wval;
    assign mask = walk_active ? w_mask : c_mask;

    assign stored = frames[sel];

    // mask bit set means keep the stored bit
    always_ff @(posedge CLK) begin
        if (wr) begin
            frames[sel] <= (stored & mask) | (wval & ~mask);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (wr && !mask.tag.valid) begin
            valid_q[sel] <= wval.tag.valid;
        end
    end

    always_comb begin
        rframe           = stored;
        rframe.tag.valid = valid_q[sel];   // stored copy of valid is ignored
    end

endmodule

// File: common/cache_types_pkg.sv
`include "cache_settings.svh"

package cache_types_pkg;
    import mem_bus_pkg::*;

    localparam int N_SETS     = `CACHE_SIZE_BYTES / (`BLOCK_WORDS * 4);
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(`BLOCK_WORDS);
    localparam int TAG_BITS   = 32 - SET_BITS - BLOCK_BITS - 2;

    typedef logic [SET_BITS-1:0] set_idx_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   idx;
        logic [BLOCK_BITS-1:0] blk;     // word within block
        logic [1:0]            bytes;
    } addr_fields_t;

    // one address read either as a whole word or split for lookup
    typedef union packed {
        word_t        raw;
        addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } cache_tag_t;

    typedef struct packed {
        cache_tag_t tag;
        block_t     data;
    } cache_frame_t;

    typedef enum logic [1:0] {
        LOOKUP,
        FETCH,
        WRITEBACK
    } ctrl_state_t;

endpackage

// File: common/mem_bus_pkg.sv
`include "cache_settings.svh"

package mem_bus_pkg;

    typedef logic [31:0] word_t;

    typedef logic [3:0] byte_en_t;       // one bit per byte lane

    // whole memory-bus block with word 0 in the low bits
    typedef word_t [`BLOCK_WORDS-1:0] block_t;

endpackage

// File: common/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// capacity in bytes as a power of 2
`define CACHE_SIZE_BYTES 1024

// words per block as a power of 2
`define BLOCK_WORDS 2

// everything at or above this bypasses the cache
`define NONCACHE_START 32'hF000_0000

`endif
